// ==== frame_pkg.sv ====
`default_nettype none

// Frame geometry and sequencer types for a 640x480 frame of 24-bit pixels
package frame_pkg;

    localparam int frame_width  = 640;                        // Pixels per line
    localparam int frame_height = 480;                        // Lines per frame
    localparam int frame_words  = frame_width * frame_height; // One bus word per pixel
    localparam int pixel_width  = 24;                         // RGB888

    localparam int fb_addr_width = 19;                        // 2^19 covers 307200 words

    typedef logic [pixel_width-1:0]   pixel_t;
    typedef logic [fb_addr_width-1:0] fb_addr_t;

    // One bit wider than the address so the count can run past frame_words
    typedef logic [fb_addr_width:0]   fb_count_t;

    // Sequencer states
    typedef enum logic [1:0] {
        fb_idle,  // Waiting for a start strobe
        fb_write, // Filling the frame with the pattern
        fb_read   // Reading the frame back
    } fb_state_t;

endpackage

`default_nettype wire

// ==== mem_pkg.sv ====
`default_nettype none

// Memory bus widths and timing of the behavioral frame memory
package mem_pkg;

    localparam int mem_data_width = 32;             // Bus word, pixel in the low 24 bits

    typedef logic [mem_data_width-1:0] mem_word_t;

    // Cycles from reset release until the memory reports ready
    localparam int mem_init_cycles = 200;

    // Accepted read to rd_data_valid, in cycles
    localparam int mem_rd_latency = 3;

    // Ready drops for one cycle in every period, like a refresh slot
    localparam int mem_stall_period = 64;

endpackage

`default_nettype wire

// ==== avl_if.sv ====
`timescale 1ns/1ns
`default_nettype none

// Request/ready memory bus between the sequencer, the memory and the checker
interface avl_if;
    import frame_pkg::*;
    import mem_pkg::*;

    fb_addr_t  addr;          // Frame word address
    logic      write_req;     // Held until accepted
    logic      read_req;      // Never high together with write_req
    mem_word_t wr_data;       // Pixel in bits 23..0
    logic      ready;         // Request accepted when high with a request
    mem_word_t rd_data;       // Returned word
    logic      rd_data_valid; // One cycle per returned word

    // Sequencer side
    modport master (
        output addr, write_req, read_req, wr_data,
        input  ready
    );

    // Memory side
    modport slave (
        input  addr, write_req, read_req, wr_data,
        output ready, rd_data, rd_data_valid
    );

    // Read-back observer
    modport monitor (
        input rd_data, rd_data_valid
    );

endinterface

`default_nettype wire

// ==== frame_buf.sv ====
`timescale 1ns/1ns
`default_nettype none

// Frame address sequencer
// Steps one word address through the whole frame for a write pass or a read pass,
// advancing only on accepted bus requests
module frame_buf (
    input  wire logic              clk_25_2m,
    input  wire logic              reset,       // Synchronous, active low
    input  wire logic              start_write, // One-cycle strobe
    input  wire logic              start_read,  // One-cycle strobe
    input  wire logic              mem_ready,   // Memory init finished
    input  wire frame_pkg::pixel_t pattern,     // Written on every word
    avl_if.master                  bus,
    output logic                   rd_start,    // Pulse in the first read-pass cycle
    output logic                   busy,
    output logic                   full         // Sticky after a full write pass
);
    import frame_pkg::*;
    import mem_pkg::*;

    fb_state_t state;
    fb_addr_t  addr_cnt;  // Next word to request
    logic      accept;    // Request taken by the memory this cycle
    logic      last_addr; // Current word is the last of the frame

    // Bus drive comes straight from the state, the address stays put until accepted
    assign bus.write_req = (state == fb_write);
    assign bus.read_req  = (state == fb_read);
    assign bus.addr      = addr_cnt;
    assign bus.wr_data   = {{(mem_data_width - pixel_width){1'b0}}, pattern}; // Top byte zero

    assign accept    = (bus.write_req || bus.read_req) && bus.ready;
    assign last_addr = (addr_cnt == fb_addr_t'(frame_words - 1));

    assign busy = (state != fb_idle);

    always_ff @(posedge clk_25_2m) begin
        if (!reset) begin
            state    <= fb_idle;
            addr_cnt <= '0;
            full     <= 1'b0;
            rd_start <= 1'b0;
        end else begin
            rd_start <= 1'b0; // Default, pulse only

            case (state)
                fb_idle: begin
                    // Strobes only count once the memory is up
                    if (mem_ready) begin
                        if (start_write) begin
                            state    <= fb_write;
                            addr_cnt <= '0;
                        end else if (start_read) begin
                            state    <= fb_read;
                            addr_cnt <= '0;
                            rd_start <= 1'b1; // Checker clears its result
                        end
                    end
                end

                fb_write, fb_read: begin
                    // Back-pressure simply holds everything
                    if (accept) begin
                        if (last_addr) begin
                            state    <= fb_idle;
                            addr_cnt <= '0;
                            if (state == fb_write)
                                full <= 1'b1; // Stays set until reset
                        end else begin
                            addr_cnt <= addr_cnt + 1'b1;
                        end
                    end
                end

                default: state <= fb_idle;
            endcase
        end
    end

    // start_read seen during a pass falls into the pass branch and is dropped

endmodule

`default_nettype wire

// ==== avl_mem.sv ====
`timescale 1ns/1ns
`default_nettype none

// Behavioral frame memory standing in for the DDR controller
// Init delay after reset, one stall cycle per period, fixed read latency
module avl_mem (
    input  wire logic clk_25_2m,
    input  wire logic reset,     // Synchronous, active low
    avl_if.slave      bus,
    output logic      mem_ready  // High once init delay is over
);
    import frame_pkg::*;
    import mem_pkg::*;

    mem_word_t mem_array [frame_words]; // One word per pixel

    logic [$clog2(mem_init_cycles)-1:0]  init_cnt;
    logic [$clog2(mem_stall_period)-1:0] stall_cnt;

    logic wr_acc; // Write accepted this cycle
    logic rd_acc; // Read accepted this cycle

    // Read return pipeline, stage 0 loaded on acceptance
    logic      vld_pipe  [mem_rd_latency];
    mem_word_t data_pipe [mem_rd_latency];

    // Init delay counter
    always_ff @(posedge clk_25_2m) begin
        if (!reset) begin
            init_cnt  <= '0;
            mem_ready <= 1'b0;
        end else if (!mem_ready) begin
            if (init_cnt == mem_init_cycles - 1)
                mem_ready <= 1'b1;
            init_cnt <= init_cnt + 1'b1;
        end
    end

    // Stall slot counter, only runs once the memory is up
    always_ff @(posedge clk_25_2m) begin
        if (!reset) begin
            stall_cnt <= '0;
        end else if (mem_ready) begin
            if (stall_cnt == mem_stall_period - 1)
                stall_cnt <= '0;
            else
                stall_cnt <= stall_cnt + 1'b1;
        end
    end

    // Ready low during init and in the last slot of each period
    assign bus.ready = mem_ready && (stall_cnt != mem_stall_period - 1);

    assign wr_acc = bus.write_req && bus.ready;
    assign rd_acc = bus.read_req && bus.ready;

    // Storage write
    always_ff @(posedge clk_25_2m) begin
        if (wr_acc)
            mem_array[bus.addr] <= bus.wr_data;
    end

    // Valid flags shift with reset
    always_ff @(posedge clk_25_2m) begin
        if (!reset) begin
            for (int i = 0; i < mem_rd_latency; i++)
                vld_pipe[i] <= 1'b0;
        end else begin
            vld_pipe[0] <= rd_acc;
            for (int i = 1; i < mem_rd_latency; i++)
                vld_pipe[i] <= vld_pipe[i-1];
        end
    end

    // Data follows its flag through the same stages
    always_ff @(posedge clk_25_2m) begin
        data_pipe[0] <= mem_array[bus.addr]; // Only meaningful when rd_acc
        for (int i = 1; i < mem_rd_latency; i++)
            data_pipe[i] <= data_pipe[i-1];
    end

    // Last stage is the bus response, in request order
    assign bus.rd_data_valid = vld_pipe[mem_rd_latency-1];
    assign bus.rd_data       = data_pipe[mem_rd_latency-1];

endmodule

`default_nettype wire

// ==== pattern_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

// Read-back checker
// Counts returned words and compares each pixel with the expected pattern
module pattern_checker (
    input  wire logic              clk_25_2m,
    input  wire logic              reset,    // Synchronous, active low
    input  wire logic              rd_start, // New read pass, clear result
    input  wire frame_pkg::pixel_t pattern,  // Expected pixel
    avl_if.monitor                 bus,
    output logic                   pass,     // Sticky
    output logic                   fail      // Sticky
);
    import frame_pkg::*;

    fb_count_t rd_cnt;   // Words seen in this pass
    fb_count_t cnt_next; // Count including the current word
    logic      mismatch;

    assign cnt_next = rd_cnt + 1'b1;
    assign mismatch = (bus.rd_data[pixel_width-1:0] != pattern); // Top byte ignored

    always_ff @(posedge clk_25_2m) begin
        if (!reset) begin
            rd_cnt <= '0;
            pass   <= 1'b0;
            fail   <= 1'b0;
        end else if (rd_start) begin
            rd_cnt <= '0;
            pass   <= 1'b0;
            fail   <= 1'b0;
        end else if (bus.rd_data_valid) begin
            // Saturate just past a frame so a runaway read cannot wrap back
            if (rd_cnt <= fb_count_t'(frame_words))
                rd_cnt <= cnt_next;

            if (mismatch || cnt_next > fb_count_t'(frame_words)) begin
                fail <= 1'b1;
                pass <= 1'b0; // Extra words revoke an earlier pass
            end else if (cnt_next == fb_count_t'(frame_words) && !fail) begin
                pass <= 1'b1; // Exactly one clean frame
            end
        end
    end

endmodule

`default_nettype wire

// ==== fb_test_top.sv ====
`timescale 1ns/1ns
`default_nettype none

// Frame-buffer self-test top
// Sequencer drives the memory, checker watches the read data
module fb_test_top (
    input  wire logic              clk_25_2m,
    input  wire logic              reset,       // Synchronous, active low
    input  wire logic              start_write, // Fill frame with pattern
    input  wire logic              start_read,  // Read back and compare
    input  wire frame_pkg::pixel_t pattern,
    output logic                   busy,        // Pass in progress
    output logic                   full,        // Frame written
    output logic                   pass,
    output logic                   fail
);

    logic mem_ready; // Memory init done
    logic rd_start;  // Read pass begins

    avl_if bus0 ();

    // Address sequencer, bus master
    frame_buf frame_buf0 (
        .clk_25_2m   (clk_25_2m),
        .reset       (reset),
        .start_write (start_write),
        .start_read  (start_read),
        .mem_ready   (mem_ready),
        .pattern     (pattern),
        .bus         (bus0.master),
        .rd_start    (rd_start),
        .busy        (busy),
        .full        (full)
    );

    // Behavioral frame memory
    avl_mem mem0 (
        .clk_25_2m (clk_25_2m),
        .reset     (reset),
        .bus       (bus0.slave),
        .mem_ready (mem_ready)
    );

    // Pass/fail decision on the returned words
    pattern_checker checker0 (
        .clk_25_2m (clk_25_2m),
        .reset     (reset),
        .rd_start  (rd_start),
        .pattern   (pattern),
        .bus       (bus0.monitor),
        .pass      (pass),
        .fail      (fail)
    );

endmodule

`default_nettype wire

// ==== tb_fb_test.sv ====
`timescale 1ns/1ns
`default_nettype none

// Testbench for the frame-buffer self-test
// Each table row writes a frame (optional), reads it back and checks pass/fail
module tb_fb_test;
    import frame_pkg::*;

    localparam int num_rows       = 5;
    localparam int pass_timeout   = 700000; // One pass is about 312000 cycles with stalls
    localparam int quiet_cycles   = 250;    // Covers the memory init delay
    localparam int quiet_timeout  = 2000;
    localparam int stray_delay    = 100;    // Cycles into a write before the stray read strobe

    logic   clk_25_2m;
    logic   reset;
    logic   start_write;
    logic   start_read;
    pixel_t pattern;
    logic   busy;
    logic   full;
    logic   pass;
    logic   fail;

    // Stimulus table of do_write, write pattern, read pattern and expected result
    logic   do_write_tbl [num_rows];
    pixel_t wr_pat_tbl   [num_rows];
    pixel_t rd_pat_tbl   [num_rows];
    logic   exp_pass_tbl [num_rows]; // 1 expects pass and 0 expects fail

    integer seed;
    int     err_count;
    int     rows_run;
    int     rows_failed;
    logic   timed_out;
    logic   wrote_once; // Expected value of full

    fb_test_top dut0 (
        .clk_25_2m   (clk_25_2m),
        .reset       (reset),
        .start_write (start_write),
        .start_read  (start_read),
        .pattern     (pattern),
        .busy        (busy),
        .full        (full),
        .pass        (pass),
        .fail        (fail)
    );

    always #5 clk_25_2m = ~clk_25_2m; // 10 ns period

    // One error line per wrong value
    task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                   input logic [31:0] got_val);
        $display("Error: time %0t, signal %s, expected %0h, got %0h",
                 $time, name, exp_val, got_val);
        err_count++;
    endtask

    task automatic pulse_write();
        @(posedge clk_25_2m);
        start_write <= 1'b1;
        @(posedge clk_25_2m);
        start_write <= 1'b0; // DUT saw the strobe on this edge
    endtask

    task automatic pulse_read();
        @(posedge clk_25_2m);
        start_read <= 1'b1;
        @(posedge clk_25_2m);
        start_read <= 1'b0;
    endtask

    // Sampled on the falling edge away from the DUT updates
    task automatic wait_idle(input int limit, output logic ok);
        int n;
        ok = 1'b0;
        n  = 0;
        while (!ok && n < limit) begin
            @(negedge clk_25_2m);
            if (!busy)
                ok = 1'b1;
            n++;
        end
    endtask

    task automatic wait_result(input int limit, output logic ok);
        int n;
        ok = 1'b0;
        n  = 0;
        while (!ok && n < limit) begin
            @(negedge clk_25_2m);
            if (pass || fail)
                ok = 1'b1;
            n++;
        end
    endtask

    // Busy must stay low for a run of cycles
    task automatic wait_quiet(input int cycles, input int limit, output logic ok);
        int n;
        int run;
        ok  = 1'b0;
        n   = 0;
        run = 0;
        while (!ok && n < limit) begin
            @(negedge clk_25_2m);
            run = busy ? 0 : run + 1;
            if (run >= cycles)
                ok = 1'b1;
            n++;
        end
    endtask

    initial begin
        logic ok;
        logic exp_pass; // Result the checker should hold between read passes
        logic exp_fail;
        int   row_errs;
        int   flip_bit;

        clk_25_2m   = 1'b0;
        reset       = 1'b0; // Held low from time zero
        start_write = 1'b0;
        start_read  = 1'b0;
        pattern     = '0;
        seed        = 38501;
        err_count   = 0;
        rows_run    = 0;
        rows_failed = 0;
        timed_out   = 1'b0;
        wrote_once  = 1'b0;
        exp_pass    = 1'b0; // Nothing read yet
        exp_fail    = 1'b0;

        // Fixed rows
        do_write_tbl[0] = 1'b1;
        wr_pat_tbl[0]   = 24'hFFFFFF;
        rd_pat_tbl[0]   = 24'hFFFFFF;
        exp_pass_tbl[0] = 1'b1;
        do_write_tbl[1] = 1'b0;
        wr_pat_tbl[1]   = 24'h000000;
        rd_pat_tbl[1]   = 24'h000000;
        exp_pass_tbl[1] = 1'b0; // Memory still holds FFFFFF
        do_write_tbl[2] = 1'b1;
        wr_pat_tbl[2]   = 24'h5A5A5A;
        rd_pat_tbl[2]   = 24'h5A5A5A;
        exp_pass_tbl[2] = 1'b1; // Clears the earlier fail

        // Random pattern and then the same pattern with one bit flipped
        wr_pat_tbl[3]   = pixel_t'($random(seed));
        do_write_tbl[3] = 1'b1;
        rd_pat_tbl[3]   = wr_pat_tbl[3];
        exp_pass_tbl[3] = 1'b1;
        flip_bit        = int'($unsigned($random(seed)) % 24);
        do_write_tbl[4] = 1'b0;
        wr_pat_tbl[4]   = 24'h000000;
        rd_pat_tbl[4]   = wr_pat_tbl[3] ^ (pixel_t'(1) << flip_bit);
        exp_pass_tbl[4] = 1'b0;

        repeat (10) @(posedge clk_25_2m);
        reset <= 1'b1;

        // All outputs quiet right after reset
        @(negedge clk_25_2m);
        if (pass !== 1'b0) report_mismatch("pass", 0, pass);
        if (fail !== 1'b0) report_mismatch("fail", 0, fail);
        if (full !== 1'b0) report_mismatch("full", 0, full);
        if (busy !== 1'b0) report_mismatch("busy", 0, busy);

        wait_quiet(quiet_cycles, quiet_timeout, ok);
        if (!ok) begin
            $display("Timeout: busy did not stay low after reset");
            timed_out = 1'b1;
        end

        for (int r = 0; r < num_rows && !timed_out; r++) begin
            row_errs = err_count;

            // A failed read may still be running from the last row
            wait_idle(pass_timeout, ok);
            if (!ok)
                $display("Timeout: busy stayed high before row %0d", r);

            if (ok && do_write_tbl[r]) begin
                @(posedge clk_25_2m);
                pattern <= wr_pat_tbl[r];
                pulse_write();
                @(negedge clk_25_2m);
                if (busy !== 1'b1) report_mismatch("busy", 1, busy);

                // Read strobe in the middle of the write must be dropped
                repeat (stray_delay) @(posedge clk_25_2m);
                pulse_read();

                wait_idle(pass_timeout, ok);
                if (!ok) begin
                    $display("Timeout: write pass in row %0d did not finish", r);
                end else begin
                    wrote_once = 1'b1;
                    if (full !== 1'b1) report_mismatch("full", 1, full);
                    if (pass !== exp_pass) report_mismatch("pass", exp_pass, pass);
                    if (fail !== exp_fail) report_mismatch("fail", exp_fail, fail);
                end
            end

            if (ok) begin
                @(posedge clk_25_2m);
                pattern <= rd_pat_tbl[r]; // Held for the whole read pass
                pulse_read();
                @(posedge clk_25_2m);     // Checker clears on this edge
                @(negedge clk_25_2m);
                if (busy !== 1'b1) report_mismatch("busy", 1, busy);
                if (pass !== 1'b0) report_mismatch("pass", 0, pass);
                if (fail !== 1'b0) report_mismatch("fail", 0, fail);

                wait_result(pass_timeout, ok);
                if (!ok) begin
                    $display("Timeout: no pass or fail in row %0d", r);
                end else begin
                    if (pass !== exp_pass_tbl[r]) report_mismatch("pass", exp_pass_tbl[r], pass);
                    if (fail !== !exp_pass_tbl[r]) report_mismatch("fail", !exp_pass_tbl[r], fail);
                    // Pass only after the last word left the sequencer
                    if (exp_pass_tbl[r] && busy !== 1'b0) report_mismatch("busy", 0, busy);
                    exp_pass = exp_pass_tbl[r]; // Sticky until the next read pass
                    exp_fail = !exp_pass_tbl[r];
                end
            end

            if (ok && full !== wrote_once) report_mismatch("full", wrote_once, full);

            if (!ok)
                timed_out = 1'b1;
            rows_run++;
            if (err_count != row_errs || !ok)
                rows_failed++;
            $display("Row %0d: write %0b, write pattern %06h, read pattern %06h, expect %s, %s",
                     r, do_write_tbl[r], wr_pat_tbl[r], rd_pat_tbl[r],
                     exp_pass_tbl[r] ? "pass" : "fail",
                     (err_count == row_errs && ok) ? "ok" : "FAILED");
        end

        $display("Rows run %0d of %0d, rows failed %0d, errors %0d, timeout %0b",
                 rows_run, num_rows, rows_failed, err_count, timed_out);
        if (err_count == 0 && !timed_out && rows_run == num_rows) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
frame_pkg.sv
mem_pkg.sv
avl_if.sv
frame_buf.sv
avl_mem.sv
pattern_checker.sv
fb_test_top.sv
tb_fb_test.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the frame-buffer self-test with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_fb_test -f build.f -o sim_fb

out=$(./obj_dir/sim_fb)
echo "$out"

if echo "$out" | grep -qx "Simulation passed"; then
    exit 0
else
    exit 1
fi
